// ==== project.f ====
src/quant_types_pkg.sv
src/quant_tables_pkg.sv
src/quant_ctrl.sv
src/quant_mult_stage.sv
src/quant_round_stage.sv
src/quantizer_top.sv
verif/quantizer_sva.sv
verif/quantizer_tb.sv

// ==== src/quant_ctrl.sv ====
/*
 * Enable chain for the quantizer pipeline. One strobe per stage,
 * plus the out_enable pulse that marks a finished block.
 */
`timescale 1ns/1ns

module quant_ctrl (
    input  logic clk,
    input  logic rst,
    input  logic enable,
    output logic mult_en,
    output logic hold_en,
    output logic round_en,
    output logic out_enable
);

    // Each strobe is the one before it, one clock later.
    // Pulses from back-to-back blocks simply follow each other down the chain
    always_ff @(posedge clk) begin
        if (rst) begin
            mult_en    <= 1'b0;
            hold_en    <= 1'b0;
            round_en   <= 1'b0;
            out_enable <= 1'b0;
        end else begin
            mult_en  <= enable;
            hold_en  <= mult_en;
            round_en <= hold_en;
            // Rises on the same edge that loads the rounded block
            out_enable <= round_en;
        end
    end

endmodule

// ==== src/quant_mult_stage.sv ====
/*
 * First datapath stage. Captures a coefficient block with sign
 * extension, then multiplies every coefficient by the reciprocal
 * of its quantization step.
 */
`timescale 1ns/1ns

module quant_mult_stage
    import quant_types_pkg::*, quant_tables_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        enable,
    input  logic        mult_en,
    input  coef_block_t coefs,
    output prod_block_t prod
);

    localparam int int_w = 32;

    // Sign-extended view of the incoming block
    logic signed [int_w-1:0] coef_ext [block_dim][block_dim];

    // Captured block, one full-width integer per position
    logic signed [int_w-1:0] coef_int [block_dim][block_dim];

    prod_block_t prod_next;

    for (genvar r = 0; r < block_dim; r++) begin : g_row
        for (genvar c = 0; c < block_dim; c++) begin : g_col
            // The reciprocal is positive, so a zero sign bit keeps the multiply signed
            localparam logic signed [recip_w:0] recip = {1'b0, recip_of(r, c)};

            assign coef_ext[r][c] = int_w'(coefs.row[r][c]);

            // Low prod_w bits only. Bits above them are dropped on purpose
            assign prod_next.row[r][c] = prod_t'(coef_int[r][c] * recip);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            coef_int <= '{default: '0};
        end else if (enable) begin
            coef_int <= coef_ext;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            prod <= '0;
        end else if (mult_en) begin
            prod <= prod_next;
        end
    end

endmodule

// ==== src/quant_round_stage.sv ====
/*
 * Second datapath stage. Holds the product block for one stage,
 * then rounds each product half up to an 11-bit quantized value.
 */
`timescale 1ns/1ns

module quant_round_stage
    import quant_types_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        hold_en,
    input  logic        round_en,
    input  prod_block_t prod,
    output coef_block_t quant
);

    prod_block_t prod_hold;
    coef_block_t rounded;

    for (genvar r = 0; r < block_dim; r++) begin : g_row
        for (genvar c = 0; c < block_dim; c++) begin : g_col
            // Integer part sits above the frac_w fraction bits.
            // bit frac_w-1 is the half, adding it rounds half up and may wrap
            assign rounded.row[r][c] = prod_hold.row[r][c][prod_w-1:frac_w]
                                     + coef_w'(prod_hold.row[r][c][frac_w-1]);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            prod_hold <= '0;
        end else if (hold_en) begin
            prod_hold <= prod;
        end
    end

    // Quant keeps its last block until the next round_en
    always_ff @(posedge clk) begin
        if (rst) begin
            quant <= '0;
        end else if (round_en) begin
            quant <= rounded;
        end
    end

endmodule

// ==== src/quant_tables_pkg.sv ====
/*
 * Standard JPEG luminance quantization table and the reciprocal
 * lookup used in place of a divider.
 */
package quant_tables_pkg;

    import quant_types_pkg::*;

    // Step sizes in row-major order, not zigzag order
    localparam logic [7:0] luma_qtable [block_size] = '{
        8'd16, 8'd11, 8'd10, 8'd16, 8'd24,  8'd40,  8'd51,  8'd61,
        8'd12, 8'd12, 8'd14, 8'd19, 8'd26,  8'd58,  8'd60,  8'd55,
        8'd14, 8'd13, 8'd16, 8'd24, 8'd40,  8'd57,  8'd69,  8'd56,
        8'd14, 8'd17, 8'd22, 8'd29, 8'd51,  8'd87,  8'd80,  8'd62,
        8'd18, 8'd22, 8'd37, 8'd56, 8'd68,  8'd109, 8'd103, 8'd77,
        8'd24, 8'd35, 8'd55, 8'd64, 8'd81,  8'd104, 8'd113, 8'd92,
        8'd49, 8'd64, 8'd78, 8'd87, 8'd103, 8'd121, 8'd120, 8'd101,
        8'd72, 8'd92, 8'd95, 8'd98, 8'd112, 8'd100, 8'd103, 8'd99
    };

    /*
     * Reciprocal of the step at (row, col), scaled by 2^frac_w and
     * rounded to nearest. The smallest step is 10, which gives 410, so
     * every entry fits in recip_w bits with room to spare.
     */
    function automatic recip_t recip_of(input int row, input int col);
        int step;
        int scaled;
        step   = int'(luma_qtable[row * block_dim + col]);
        scaled = (1 << frac_w) + step / 2;
        return recip_t'(scaled / step);
    endfunction

endpackage

// ==== src/quant_types_pkg.sv ====
/*
 * Widths, element types and block types shared by the quantizer
 * datapath stages and by the testbench.
 */
package quant_types_pkg;

    // An 8x8 block of DCT coefficients
    localparam int block_dim  = 8;
    localparam int block_size = block_dim * block_dim;

    // Coefficients and quantized values share one width
    localparam int coef_w = 11;

    // Reciprocals carry frac_w fraction bits, so a step of 1 maps to 4096
    localparam int recip_w = 13;
    localparam int frac_w  = 12;

    // Only the low bits of each product are kept
    localparam int prod_w = 23;

    typedef logic signed [coef_w-1:0] coef_t;
    typedef logic [recip_w-1:0]       recip_t;
    typedef logic [prod_w-1:0]        prod_t;

    typedef coef_t [block_dim-1:0] coef_row_t;
    typedef prod_t [block_dim-1:0] prod_row_t;

    // Row r, column c is row[r][c]
    typedef struct packed {
        coef_row_t [block_dim-1:0] row;
    } coef_block_t;

    typedef struct packed {
        prod_row_t [block_dim-1:0] row;
    } prod_block_t;

endpackage

// ==== src/quantizer_top.sv ====
/*
 * Luminance quantizer for one 8x8 DCT block per enable strobe.
 * Result and out_enable appear three clocks after the strobe is sampled.
 */
`timescale 1ns/1ns

module quantizer_top
    import quant_types_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        enable,
    input  coef_block_t coefs,
    output coef_block_t quant,
    output logic        out_enable
);

    logic        mult_en;
    logic        hold_en;
    logic        round_en;
    prod_block_t prod;

    quant_ctrl u_ctrl (
        .clk        (clk),
        .rst        (rst),
        .enable     (enable),
        .mult_en    (mult_en),
        .hold_en    (hold_en),
        .round_en   (round_en),
        .out_enable (out_enable)
    );

    quant_mult_stage u_mult (
        .clk     (clk),
        .rst     (rst),
        .enable  (enable),
        .mult_en (mult_en),
        .coefs   (coefs),
        .prod    (prod)
    );

    quant_round_stage u_round (
        .clk      (clk),
        .rst      (rst),
        .hold_en  (hold_en),
        .round_en (round_en),
        .prod     (prod),
        .quant    (quant)
    );

endmodule

// ==== verif/quantizer_sva.sv ====
/*
 * Concurrent assertions on the quantizer enable chain,
 * bound into quant_ctrl.
 */
`timescale 1ns/1ns

module quantizer_sva (
    input logic clk,
    input logic rst,
    input logic enable,
    input logic mult_en,
    input logic hold_en,
    input logic round_en,
    input logic out_enable
);

    // Enable sampled at edge N drives out_enable after edge N+3, seen at the next sample
    property out_follows_enable;
        @(posedge clk) disable iff (rst)
            !$past(rst, 1) && !$past(rst, 2) && !$past(rst, 3) && !$past(rst, 4)
            |-> out_enable == $past(enable, 4);
    endproperty

    property chain_cleared_by_reset;
        @(posedge clk) $past(rst) |-> !mult_en && !hold_en && !round_en && !out_enable;
    endproperty

    // A two-cycle out_enable needs two input strobes in a row
    property wide_pulse_needs_two_enables;
        @(posedge clk) disable iff (rst)
            out_enable && $past(out_enable) |-> $past(enable, 4) && $past(enable, 5);
    endproperty

    a_out_follows_enable : assert property (out_follows_enable)
        else $error("out_enable does not follow enable by three cycles");

    a_chain_cleared : assert property (chain_cleared_by_reset)
        else $error("stage enables not cleared after reset");

    a_wide_pulse : assert property (wide_pulse_needs_two_enables)
        else $error("out_enable high for two cycles without two enables");

endmodule

bind quant_ctrl quantizer_sva ctrl_sva (
    .clk        (clk),
    .rst        (rst),
    .enable     (enable),
    .mult_en    (mult_en),
    .hold_en    (hold_en),
    .round_en   (round_en),
    .out_enable (out_enable)
);

// ==== verif/quantizer_tb.sv ====
/*
 * Directed testbench for the luminance quantizer. Holds the clock,
 * reset, a reference model of the rounding, compare tasks and the
 * reset, single, boundary, back-to-back and hold tests.
 */
`timescale 1ns/1ns

module quantizer_tb
    import quant_types_pkg::*, quant_tables_pkg::*;
();

    localparam int latency     = 3;
    localparam int max_wait    = 20;
    localparam int hold_cycles = 8;

    logic        clk;
    logic        rst;
    logic        enable;
    coef_block_t coefs;
    coef_block_t quant;
    logic        out_enable;

    int unsigned lcg_state = 32'd82199;

    quantizer_top dut0 (
        .clk        (clk),
        .rst        (rst),
        .enable     (enable),
        .coefs      (coefs),
        .quant      (quant),
        .out_enable (out_enable)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    function automatic int unsigned next_random();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic coef_block_t random_block();
        coef_block_t b;
        for (int r = 0; r < block_dim; r++) begin
            for (int c = 0; c < block_dim; c++) begin
                // Upper bits of the LCG are the better-mixed ones
                b.row[r][c] = coef_t'(next_random() >> 16);
            end
        end
        return b;
    endfunction

    // Expected quantized value from coef times round(4096 / step)
    // The low 23 bits are kept and the integer part gets the half bit added, wrapping at 11 bits
    function automatic coef_t model_quant(input coef_t coef, input int row, input int col);
        int                step;
        int                recip;
        longint            product;
        logic [prod_w-1:0] low;
        logic [coef_w-1:0] q;
        step    = int'(luma_qtable[row * block_dim + col]);
        recip   = ((1 << frac_w) + step / 2) / step;
        product = longint'(coef) * longint'(recip);
        low     = product[prod_w-1:0];
        q       = low[prod_w-1:frac_w] + low[frac_w-1];
        return coef_t'(q);
    endfunction

    function automatic coef_block_t model_block(input coef_block_t in);
        coef_block_t out;
        for (int r = 0; r < block_dim; r++) begin
            for (int c = 0; c < block_dim; c++) begin
                out.row[r][c] = model_quant(in.row[r][c], r, c);
            end
        end
        return out;
    endfunction

    // Extremes in the first two rows, then values near half a step and beyond
    function automatic coef_block_t boundary_block();
        coef_t       extremes [block_dim];
        coef_block_t b;
        int          step;
        int          half;
        int          mag;
        extremes = '{coef_t'(-1024), coef_t'(1023), coef_t'(-1), coef_t'(0),
                     coef_t'(8), coef_t'(-8), coef_t'(1), coef_t'(-2)};
        for (int c = 0; c < block_dim; c++) begin
            b.row[0][c] = extremes[c];
            b.row[1][c] = extremes[block_dim - 1 - c];
        end
        for (int r = 2; r < block_dim; r++) begin
            for (int c = 0; c < block_dim; c++) begin
                step = int'(luma_qtable[r * block_dim + c]);
                half = (r % 2 == 0) ? step / 2 : (step + 1) / 2;
                mag  = ((r - 2) / 2) * step + half;
                b.row[r][c] = coef_t'((c % 2 == 0) ? mag : -mag);
            end
        end
        return b;
    endfunction

    task automatic stop_with_failure(input string line);
        $display("%s", line);
        $display("TEST RESULT: FAIL");
        $fatal(1, "stopping at the first failure");
    endtask

    task automatic report_mismatch(input string msg);
        stop_with_failure($sformatf("mismatch at %0t ns: %s", $time, msg));
    endtask

    task automatic check_block(input coef_block_t actual, input coef_block_t expected,
                               input string what);
        coef_t got;
        coef_t want;
        bit    found;
        found = 1'b0;
        for (int r = 0; r < block_dim && !found; r++) begin
            for (int c = 0; c < block_dim && !found; c++) begin
                got  = actual.row[r][c];
                want = expected.row[r][c];
                if (got !== want) begin
                    found = 1'b1;
                    report_mismatch($sformatf("%s row %0d col %0d got %0d expected %0d",
                                              what, r, c, got, want));
                end
            end
        end
    endtask

    task automatic check_strobe(input logic actual, input logic expected, input string what);
        if (actual !== expected) begin
            report_mismatch($sformatf("%s out_enable is %b, expected %b",
                                      what, actual, expected));
        end
    endtask

    task automatic check_latency(input int actual, input int expected, input string what);
        if (actual != expected) begin
            report_mismatch($sformatf("%s result after %0d edges, expected %0d",
                                      what, actual, expected));
        end
    endtask

    // Inputs change and outputs are sampled 1 ns after each rising edge
    task automatic step_clock();
        @(posedge clk);
        #1;
    endtask

    task automatic present_block(input coef_block_t b);
        enable = 1'b1;
        coefs  = b;
        step_clock();
    endtask

    task automatic release_enable();
        enable = 1'b0;
    endtask

    task automatic wait_for_out_enable(output int edges);
        edges = 0;
        while (out_enable !== 1'b1) begin
            if (edges >= max_wait) begin
                stop_with_failure("out_enable did not rise within 20 cycles");
            end
            step_clock();
            edges++;
        end
    endtask

    task automatic check_after_reset();
        coef_block_t zero;
        zero = '0;
        check_block(quant, zero, "after reset");
        check_strobe(out_enable, 1'b0, "after reset");
        // Idle cycles must not disturb the cleared pipeline
        repeat (2) step_clock();
        check_block(quant, zero, "idle after reset");
        check_strobe(out_enable, 1'b0, "idle after reset");
    endtask

    task automatic quantize_one_block(input coef_block_t b, input string what);
        coef_block_t expected;
        int          edges;
        expected = model_block(b);
        present_block(b);
        release_enable();
        wait_for_out_enable(edges);
        check_latency(edges, latency, what);
        check_block(quant, expected, what);
        step_clock();
        check_strobe(out_enable, 1'b0, {what, " pulse end"});
        check_block(quant, expected, {what, " after pulse"});
    endtask

    task automatic stream_three_blocks();
        coef_block_t blocks [3];
        int          edges;
        for (int k = 0; k < 3; k++) begin
            blocks[k] = random_block();
        end
        for (int k = 0; k < 3; k++) begin
            present_block(blocks[k]);
        end
        release_enable();
        wait_for_out_enable(edges);
        // Two of the three latency edges passed while the later blocks went in
        check_latency(edges, latency - 2, "back-to-back");
        for (int k = 0; k < 3; k++) begin
            check_strobe(out_enable, 1'b1, $sformatf("back-to-back block %0d", k));
            check_block(quant, model_block(blocks[k]), $sformatf("back-to-back block %0d", k));
            step_clock();
        end
        check_strobe(out_enable, 1'b0, "after back-to-back");
    endtask

    task automatic hold_after_result();
        coef_block_t b;
        coef_block_t expected;
        int          edges;
        b        = random_block();
        expected = model_block(b);
        present_block(b);
        release_enable();
        wait_for_out_enable(edges);
        check_latency(edges, latency, "hold setup");
        check_block(quant, expected, "hold setup");
        for (int i = 0; i < hold_cycles; i++) begin
            coefs = random_block();
            step_clock();
            check_strobe(out_enable, 1'b0, $sformatf("hold cycle %0d", i));
            check_block(quant, expected, $sformatf("hold cycle %0d", i));
        end
    endtask

    initial begin
        rst    = 1'b1;
        enable = 1'b0;
        coefs  = '0;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;

        check_after_reset();
        quantize_one_block(random_block(), "single block");
        quantize_one_block(boundary_block(), "boundary block");
        stream_three_blocks();
        hold_after_result();

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule
